// File: rtl/ecc_pkg.sv
package ecc_pkg;

    localparam int data_w = 64;
    localparam int code_w = 72;
    localparam int synd_w = 7;

    typedef logic [data_w-1:0] data_t;
    typedef logic [code_w-1:0] code_t;      // Bit n is code word position n
    typedef logic [synd_w-1:0] syndrome_t;

    typedef enum logic [1:0] {
        st_ok,
        st_corrected,
        st_uncorrectable,
        st_illegal
    } status_t;

    // XOR of the indices of all set positions 1 to 71
    function automatic syndrome_t ecc_syndrome(input code_t c);
        syndrome_t s;
        s = '0;
        for (int p = 1; p < code_w; p++) begin
            if (c[p])
                s ^= syndrome_t'(p);
        end
        return s;
    endfunction

    function automatic code_t ecc_encode(input data_t d);
        code_t     c;
        syndrome_t s;
        int        j;
        c = '0;
        j = 0;
        for (int p = 3; p < code_w; p++) begin
            if ((p & (p - 1)) != 0) begin   // Powers of two hold check bits
                c[p] = d[j];
                j++;
            end
        end
        // With check positions still zero the syndrome is the check vector
        s = ecc_syndrome(c);
        for (int k = 0; k < synd_w; k++)
            c[1 << k] = s[k];
        c[0] = ^c[code_w-1:1];              // Overall parity
        return c;
    endfunction

    function automatic data_t ecc_extract(input code_t c);
        data_t d;
        int    j;
        d = '0;
        j = 0;
        for (int p = 3; p < code_w; p++) begin
            if ((p & (p - 1)) != 0) begin
                d[j] = c[p];
                j++;
            end
        end
        return d;
    endfunction

endpackage

// File: rtl/cmd_pkg.sv
package cmd_pkg;

    localparam int addr_w = 8;
    localparam int depth  = 1 << addr_w;    // Words in the RAM
    localparam int op_w   = 3;

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [op_w-1:0]   op_t;

    // Opcodes on the command port, 5 to 7 are illegal
    localparam op_t op_write     = 3'd0;
    localparam op_t op_read      = 3'd1;
    localparam op_t op_write_raw = 3'd2;
    localparam op_t op_read_raw  = 3'd3;
    localparam op_t op_scrub     = 3'd4;

    typedef enum logic [2:0] {
        k_write,        // Also write raw, word already final
        k_read,
        k_read_raw,
        k_scrub,
        k_illegal
    } kind_t;

endpackage

// File: rtl/mem_if.sv
`timescale 1ns/1ps

interface mem_if;
    import cmd_pkg::*;
    import ecc_pkg::*;

    // Request, decode to execute
    logic  req_valid;
    logic  req_ready;
    kind_t req_kind;
    addr_t req_addr;
    code_t req_word;

    // Response slot reservation, execute to result
    logic  rd_issue;       // One pulse per access started
    kind_t rd_kind;
    logic  rd_free;        // Room for one more response

    modport req_src (
        output req_valid, req_kind, req_addr, req_word,
        input  req_ready
    );

    modport req_snk (
        input  req_valid, req_kind, req_addr, req_word,
        output req_ready
    );

    modport rd_src (
        output rd_issue, rd_kind,
        input  rd_free
    );

    modport rd_snk (
        input  rd_issue, rd_kind,
        output rd_free
    );

endinterface

// File: rtl/bram_256_72.sv
`timescale 1ns/1ps

module bram_256_72 (
    input  logic           clk,
    input  logic           rst,
    input  cmd_pkg::addr_t addr,
    input  logic           en,
    input  logic           we,
    input  ecc_pkg::code_t wr,
    output ecc_pkg::code_t rd
);
    import cmd_pkg::*;
    import ecc_pkg::*;

    code_t ram [depth];

    always_ff @(posedge clk) begin
        if (en && we)
            ram[addr] <= wr;
    end

    // Output register, write-first, synchronous reset like the block RAM SSR
    always_ff @(posedge clk) begin
        if (rst)
            rd <= '0;
        else if (en)
            rd <= we ? wr : ram[addr];
    end

endmodule

// File: rtl/cmd_decode.sv
`timescale 1ns/1ps

module cmd_decode (
    input  logic           clk,
    input  logic           rst,
    input  logic           cmd_valid,
    output logic           cmd_ready,
    input  cmd_pkg::op_t   cmd_op,
    input  cmd_pkg::addr_t cmd_addr,
    input  ecc_pkg::code_t cmd_data,
    mem_if.req_src         req
);
    import cmd_pkg::*;
    import ecc_pkg::*;

    logic  running;            // Low in reset and the cycle after
    logic  take;
    kind_t kind;
    code_t word;

    assign take      = cmd_valid && cmd_ready;
    assign cmd_ready = running && (!req.req_valid || req.req_ready);

    always_comb begin
        word = cmd_data;                    // Raw words pass untouched
        case (cmd_op)
            op_write: begin
                kind = k_write;
                word = ecc_encode(cmd_data[data_w-1:0]);
            end
            op_write_raw: kind = k_write;
            op_read:      kind = k_read;
            op_read_raw:  kind = k_read_raw;
            op_scrub:     kind = k_scrub;
            default:      kind = k_illegal;
        endcase
    end

    // One entry holding register
    always_ff @(posedge clk) begin
        if (rst) begin
            running       <= 1'b0;
            req.req_valid <= 1'b0;
        end else begin
            running <= 1'b1;
            if (take)
                req.req_valid <= 1'b1;
            else if (req.req_ready)
                req.req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            req.req_kind <= kind;
            req.req_addr <= cmd_addr;
            req.req_word <= word;
        end
    end

endmodule

// File: rtl/ecc_execute.sv
`timescale 1ns/1ps

module ecc_execute (
    input  logic           clk,
    input  logic           rst,
    mem_if.req_snk         req,
    mem_if.rd_src          rd,
    input  logic           fix_valid,
    input  logic           fix_write,
    input  ecc_pkg::code_t fix_word,
    output cmd_pkg::addr_t mem_addr,
    output logic           mem_en,
    output logic           mem_we,
    output ecc_pkg::code_t mem_wr
);
    import cmd_pkg::*;

    typedef enum logic [1:0] {
        idle,
        fix_wait,           // Scrub read out, result not back yet
        fix_write_state     // Write corrected word back
    } state_t;

    state_t state;
    addr_t  scrub_addr;
    logic   accept;
    logic   write_back;

    //////////////////////////////////////////////////////////////////////
    // Issue, only with a free response slot
    //////////////////////////////////////////////////////////////////////

    assign req.req_ready = (state == idle) && rd.rd_free;
    assign accept        = req.req_valid && req.req_ready;
    assign write_back    = (state == fix_write_state);

    assign rd.rd_issue = accept;        // Illegal kinds reserve a slot too
    assign rd.rd_kind  = req.req_kind;

    //////////////////////////////////////////////////////////////////////
    // RAM port
    //////////////////////////////////////////////////////////////////////

    assign mem_en   = (accept && req.req_kind != k_illegal) || write_back;
    assign mem_we   = (accept && req.req_kind == k_write) || write_back;
    assign mem_addr = (state == idle) ? req.req_addr : scrub_addr;
    assign mem_wr   = write_back ? fix_word : req.req_word;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (accept && req.req_kind == k_scrub)
                        state <= fix_wait;
                end
                fix_wait: begin
                    if (fix_valid)
                        state <= fix_write ? fix_write_state : idle;
                end
                default: state <= idle;
            endcase
        end
    end

    // Scrub address kept for the write-back
    always_ff @(posedge clk) begin
        if (accept)
            scrub_addr <= req.req_addr;
    end

endmodule

// File: rtl/ecc_result.sv
`timescale 1ns/1ps

module ecc_result (
    input  logic             clk,
    input  logic             rst,
    mem_if.rd_snk            rd,
    input  ecc_pkg::code_t   mem_rd,
    output logic             fix_valid,
    output logic             fix_write,
    output ecc_pkg::code_t   fix_word,
    output logic             rsp_valid,
    input  logic             rsp_ready,
    output ecc_pkg::code_t   rsp_data,
    output ecc_pkg::status_t rsp_status
);
    import cmd_pkg::*;
    import ecc_pkg::*;

    logic       pend_valid;     // Access issued last cycle, RAM data now
    kind_t      pend_kind;
    syndrome_t  syn;
    logic       odd;
    status_t    chk_status;
    code_t      fixed;
    code_t      res_data;
    status_t    res_status;
    code_t      q_data [2];
    status_t    q_status [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] cnt;
    logic       push;
    logic       pop;
    logic       scrub;

    //////////////////////////////////////////////////////////////////////
    // Check and correct
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        syn   = ecc_syndrome(mem_rd);
        odd   = ^mem_rd;
        // Odd parity, single error at position syn (0 means parity bit)
        fixed = odd ? (mem_rd ^ (code_t'(1) << syn)) : mem_rd;
        if (odd)
            chk_status = st_corrected;
        else if (syn != '0)
            chk_status = st_uncorrectable;
        else
            chk_status = st_ok;
    end

    always_comb begin
        res_data   = '0;
        res_status = st_ok;
        case (pend_kind)
            k_read, k_scrub: begin
                res_data   = {8'h00, ecc_extract(fixed)};
                res_status = chk_status;
            end
            k_read_raw: res_data   = mem_rd;
            k_illegal:  res_status = st_illegal;
            default: ;                          // Writes answer zero, ok
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Two entry response queue
    //////////////////////////////////////////////////////////////////////

    assign push       = pend_valid;
    assign pop        = rsp_valid && rsp_ready;
    assign scrub      = pend_valid && pend_kind == k_scrub;
    assign rsp_valid  = (cnt != 2'd0);
    assign rsp_data   = q_data[rd_ptr];
    assign rsp_status = q_status[rd_ptr];
    assign rd.rd_free = (cnt == 2'd0) || (cnt == 2'd1 && !pend_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_valid <= 1'b0;
            wr_ptr     <= 1'b0;
            rd_ptr     <= 1'b0;
            cnt        <= 2'd0;
            fix_valid  <= 1'b0;
            fix_write  <= 1'b0;
        end else begin
            pend_valid <= rd.rd_issue;
            fix_valid  <= scrub;
            fix_write  <= scrub && chk_status == st_corrected;
            if (push)
                wr_ptr <= !wr_ptr;
            if (pop)
                rd_ptr <= !rd_ptr;
            case ({push, pop})
                2'b10:   cnt <= cnt + 2'd1;
                2'b01:   cnt <= cnt - 2'd1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        pend_kind <= rd.rd_kind;
        if (push) begin
            q_data[wr_ptr]   <= res_data;
            q_status[wr_ptr] <= res_status;
        end
        if (scrub)
            fix_word <= fixed;      // Held for the write-back cycle
    end

endmodule

// File: rtl/ecc_mem_top.sv
`timescale 1ns/1ps

module ecc_mem_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             cmd_valid,
    output logic             cmd_ready,
    input  cmd_pkg::op_t     cmd_op,
    input  cmd_pkg::addr_t   cmd_addr,
    input  ecc_pkg::code_t   cmd_data,
    output logic             rsp_valid,
    input  logic             rsp_ready,
    output ecc_pkg::code_t   rsp_data,
    output ecc_pkg::status_t rsp_status
);
    import cmd_pkg::*;
    import ecc_pkg::*;

    logic  fix_valid;
    logic  fix_write;
    code_t fix_word;
    addr_t mem_addr;
    logic  mem_en;
    logic  mem_we;
    code_t mem_wr;
    code_t mem_rd;      // Straight to result, one cycle after issue

    mem_if bus ();

    //////////////////////////////////////////////////////////////////////
    // Pipeline, decode then execute then result
    //////////////////////////////////////////////////////////////////////

    cmd_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_op    (cmd_op),
        .cmd_addr  (cmd_addr),
        .cmd_data  (cmd_data),
        .req       (bus.req_src)
    );

    ecc_execute u_execute (
        .clk       (clk),
        .rst       (rst),
        .req       (bus.req_snk),
        .rd        (bus.rd_src),
        .fix_valid (fix_valid),
        .fix_write (fix_write),
        .fix_word  (fix_word),
        .mem_addr  (mem_addr),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_wr    (mem_wr)
    );

    ecc_result u_result (
        .clk        (clk),
        .rst        (rst),
        .rd         (bus.rd_snk),
        .mem_rd     (mem_rd),
        .fix_valid  (fix_valid),
        .fix_write  (fix_write),
        .fix_word   (fix_word),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_data   (rsp_data),
        .rsp_status (rsp_status)
    );

    bram_256_72 u_ram (
        .clk  (clk),
        .rst  (rst),
        .addr (mem_addr),
        .en   (mem_en),
        .we   (mem_we),
        .wr   (mem_wr),
        .rd   (mem_rd)
    );

endmodule

// File: test/tb_ecc_mem.sv
`timescale 1ns/1ps

module tb_ecc_mem;
    import ecc_pkg::*;
    import cmd_pkg::*;

    localparam int max_rows    = 64;
    localparam int cmd_timeout = 100;   // Cycles
    localparam int rsp_timeout = 200;

    logic    clk = 1'b0;
    logic    rst;
    logic    cmd_valid;
    logic    cmd_ready;
    op_t     cmd_op;
    addr_t   cmd_addr;
    code_t   cmd_data;
    logic    rsp_valid;
    logic    rsp_ready;
    code_t   rsp_data;
    status_t rsp_status;

    // Stimulus and expected response, one row per command
    int      n_rows;
    int      row_test [max_rows];
    op_t     row_op   [max_rows];
    addr_t   row_addr [max_rows];
    code_t   row_data [max_rows];
    code_t   row_exp  [max_rows];
    status_t row_st   [max_rows];

    logic [31:0] lcg_state;
    int          checks = 0;
    int          errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    logic        timed_out = 1'b0;

    always #20 clk = ~clk;

    ecc_mem_top dut (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_op     (cmd_op),
        .cmd_addr   (cmd_addr),
        .cmd_data   (cmd_data),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_data   (rsp_data),
        .rsp_status (rsp_status)
    );

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic data_t rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi, lo};
    endfunction

    // SECDED word built from the position rule
    function automatic code_t ref_encode(input data_t d);
        code_t c;
        int    j;
        c = '0;
        j = 0;
        for (int p = 1; p < 72; p++) begin
            if ($countones(p) != 1) begin   // Data position
                c[p] = d[j];
                j++;
            end
        end
        for (int k = 0; k < 7; k++) begin
            for (int p = 3; p < 72; p++) begin
                if ($countones(p) != 1 && ((p >> k) & 1) != 0)
                    c[1 << k] ^= c[p];
            end
        end
        c[0] = ^c[71:1];
        return c;
    endfunction

    task automatic add_row(input int test, input op_t op, input addr_t addr,
                           input code_t data, input code_t exp, input status_t st);
        row_test[n_rows] = test;
        row_op[n_rows]   = op;
        row_addr[n_rows] = addr;
        row_data[n_rows] = data;
        row_exp[n_rows]  = exp;
        row_st[n_rows]   = st;
        n_rows++;
    endtask

    task automatic build_table();
        data_t d [4];
        data_t v;
        code_t c;
        code_t bad;
        addr_t a;
        int    flip_pos [4];
        flip_pos[0] = 3;    // Data bit 0
        flip_pos[1] = 16;   // Check bit 4
        flip_pos[2] = 0;    // Overall parity
        flip_pos[3] = 71;   // Data bit 63
        n_rows = 0;
        // Round trip, the upper command bits are ignored by an encoded write
        for (int i = 0; i < 4; i++) begin
            d[i] = rand64();
            add_row(1, op_write, addr_t'(8'h03 + 8'h21 * i), {8'ha5, d[i]}, '0, st_ok);
        end
        for (int i = 0; i < 4; i++) begin
            a = addr_t'(8'h03 + 8'h21 * i);
            add_row(1, op_read, a, '0, {8'h00, d[i]}, st_ok);
            add_row(1, op_read_raw, a, '0, ref_encode(d[i]), st_ok);
        end
        // Single-bit faults
        for (int f = 0; f < 4; f++) begin
            a   = addr_t'(8'h80 + f);
            v   = rand64();
            c   = ref_encode(v);
            bad = c ^ (code_t'(1) << flip_pos[f]);
            add_row(2, op_write_raw, a, bad, '0, st_ok);
            add_row(2, op_read, a, '0, {8'h00, v}, st_corrected);
            add_row(2, op_read_raw, a, '0, bad, st_ok);
            add_row(2, op_scrub, a, '0, {8'h00, v}, st_corrected);
            add_row(2, op_read_raw, a, '0, c, st_ok);
        end
        // Double-bit faults
        v   = rand64();
        bad = ref_encode(v) ^ 72'h6;            // Check bits 0 and 1
        add_row(3, op_write_raw, 8'h90, bad, '0, st_ok);
        add_row(3, op_read, 8'h90, '0, {8'h00, v}, st_uncorrectable);
        add_row(3, op_scrub, 8'h90, '0, {8'h00, v}, st_uncorrectable);
        add_row(3, op_read_raw, 8'h90, '0, bad, st_ok);
        bad = ref_encode(v) ^ 72'h28;           // Positions 3 and 5
        add_row(3, op_write_raw, 8'h91, bad, '0, st_ok);
        add_row(3, op_read, 8'h91, '0, {8'h00, v ^ 64'h3}, st_uncorrectable);
        add_row(3, op_scrub, 8'h91, '0, {8'h00, v ^ 64'h3}, st_uncorrectable);
        add_row(3, op_read_raw, 8'h91, '0, bad, st_ok);
        // Illegal opcodes leave the word alone
        v = rand64();
        add_row(4, op_write, 8'h5c, {8'h00, v}, '0, st_ok);
        for (int k = 5; k < 8; k++)
            add_row(4, op_t'(k), 8'h5c, {8'hff, rand64()}, '0, st_illegal);
        add_row(4, op_read, 8'h5c, '0, {8'h00, v}, st_ok);
        // Mixed stream, run under back-pressure
        for (int i = 0; i < 4; i++) begin
            d[i] = rand64();
            add_row(5, op_write, addr_t'(8'hc0 + i), {8'h00, d[i]}, '0, st_ok);
        end
        for (int i = 0; i < 4; i++) begin
            a = addr_t'(8'hc0 + i);
            add_row(5, op_read, a, '0, {8'h00, d[i]}, st_ok);
            add_row(5, op_scrub, a, '0, {8'h00, d[i]}, st_ok);
            if (i == 1)
                add_row(5, 3'd6, a, '0, '0, st_illegal);
            add_row(5, op_read_raw, a, '0, ref_encode(d[i]), st_ok);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Command and response sides
    //////////////////////////////////////////////////////////////////////

    task automatic send_commands();
        int wait_cnt;
        for (int i = 0; i < n_rows && !timed_out; i++) begin
            cmd_valid = 1'b1;
            cmd_op    = row_op[i];
            cmd_addr  = row_addr[i];
            cmd_data  = row_data[i];
            wait_cnt  = 0;
            while (!cmd_ready && wait_cnt < cmd_timeout) begin
                @(negedge clk);
                wait_cnt++;
            end
            if (cmd_ready) begin
                @(negedge clk);         // Taken on the rising edge before
            end else begin
                $display("Timeout: command %0d was not accepted within %0d cycles",
                         i, cmd_timeout);
                timed_out = 1'b1;
            end
        end
        cmd_valid = 1'b0;
    endtask

    task automatic check_response(input int i);
        checks++;
        if (rsp_data !== row_exp[i]) begin
            $display("Error at %0d ns: row %0d op %0d addr %h data %h, expected %h",
                     $time, i, row_op[i], row_addr[i], rsp_data, row_exp[i]);
            errors++;
        end
        checks++;
        if (rsp_status !== row_st[i]) begin
            $display("Error at %0d ns: row %0d op %0d addr %h status %s, expected %s",
                     $time, i, row_op[i], row_addr[i], rsp_status.name(),
                     row_st[i].name());
            errors++;
        end
    endtask

    task automatic report_test(input int t, input int n_checks, input int n_errors);
        string name;
        case (t)
            1:       name = "round trip";
            2:       name = "single-bit fault";
            3:       name = "double-bit fault";
            4:       name = "illegal opcodes";
            default: name = "back-pressure and order";
        endcase
        $display("Test %0d %-24s %0d checks, %0d errors: %s", t, name, n_checks,
                 n_errors, (n_errors == 0) ? "ok" : "FAILED");
        if (n_errors == 0)
            tests_passed++;
        else
            tests_failed++;
    endtask

    task automatic collect_responses();
        int          wait_cnt;
        int          chk_base;
        int          err_base;
        logic        taken;
        logic [31:0] r;
        chk_base = 0;
        err_base = 0;
        for (int i = 0; i < n_rows && !timed_out; i++) begin
            taken    = 1'b0;
            wait_cnt = 0;
            while (!taken && wait_cnt < rsp_timeout) begin
                @(negedge clk);
                r         = next_rand();
                rsp_ready = (row_test[i] == 5) ? r[16] : 1'b1;
                if (rsp_valid && rsp_ready) begin   // Taken on the next rising edge
                    check_response(i);
                    taken = 1'b1;
                end
                wait_cnt++;
            end
            if (!taken) begin
                $display("Timeout: no response for command %0d within %0d cycles",
                         i, rsp_timeout);
                timed_out = 1'b1;
            end else if (i == n_rows - 1 || row_test[i + 1] != row_test[i]) begin
                report_test(row_test[i], checks - chk_base, errors - err_base);
                chk_base = checks;
                err_base = errors;
            end
        end
    endtask

    // Nothing may follow the last response
    task automatic check_idle();
        rsp_ready = 1'b1;
        for (int n = 0; n < 10; n++) begin
            @(negedge clk);
            if (rsp_valid) begin
                $display("Error at %0d ns: response beyond the last command", $time);
                errors++;
            end
        end
    endtask

    initial begin
        lcg_state = 32'h370c_649c;
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd_op    = '0;
        cmd_addr  = '0;
        cmd_data  = '0;
        rsp_ready = 1'b0;
        build_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        fork
            send_commands();
            collect_responses();
        join
        if (!timed_out)
            check_idle();
        $display("Tests %0d passed, %0d failed, %0d checks, %0d errors",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0 && !timed_out)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// File: sim.f
rtl/ecc_pkg.sv
rtl/cmd_pkg.sv
rtl/mem_if.sv
rtl/bram_256_72.sv
rtl/cmd_decode.sv
rtl/ecc_execute.sv
rtl/ecc_result.sv
rtl/ecc_mem_top.sv
test/tb_ecc_mem.sv

// File: Makefile
SRCS := $(shell cat sim.f)
BIN  := obj_dir/Vtb_ecc_mem

.PHONY: run clean

run: $(BIN)
	$(BIN) > sim.log 2>&1
	cat sim.log
	! grep -q "Regression failed" sim.log

$(BIN): sim.f $(SRCS)
	verilator --binary --timing -j 0 --top-module tb_ecc_mem -f sim.f

clean:
	rm -rf obj_dir sim.log
